// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := branch_predictor_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/bp_pkg.sv ====
package bp_pkg;

  // address and table geometry
  localparam int ADDR_W      = 32;
  localparam int BTB_ENTRIES = 32;
  localparam int BTB_IDX_W   = 5;
  localparam int INSTR_BYTES = 4;

  // instruction address
  typedef logic [ADDR_W-1:0] addr_t;

  // index of one table entry
  typedef logic [BTB_IDX_W-1:0] slot_idx_t;

  // fetch starts here after reset
  localparam addr_t RESET_PC = 32'h0000_1000;

  // 2-bit saturating direction counter, upper half predicts taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } ctr_t;

  // resolved branch or flush record coming from execute
  typedef struct packed {
    logic  valid;
    // clear for plain redirects, table is left alone then
    logic  branch;
    logic  taken;
    addr_t pc;
    addr_t target;
    // next pc that fetch actually used after this instruction
    addr_t pred_next;
  } resolve_t;

  // table write request
  typedef struct packed {
    logic  valid;
    logic  taken;
    addr_t pc;
    addr_t target;
  } update_t;

  // lookup answer for the current fetch pc
  typedef struct packed {
    logic  taken;
    addr_t target;
  } predict_t;

endpackage

// ==== logic/branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor
  import bp_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  resolve_t resolve,
  output addr_t    fetch_pc,
  output predict_t predict,
  output logic     mispredict
);

  update_t update;
  logic    redirect;
  addr_t   redirect_pc;

  // execute side, registers outcomes and flags mispredicts
  resolve_stage u_resolve (
    .clk         (clk),
    .reset       (reset),
    .resolve     (resolve),
    .update      (update),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mispredict  (mispredict)
  );

  // lookup on the current fetch pc, written from resolve
  branch_target_table u_btb (
    .clk       (clk),
    .reset     (reset),
    .lookup_pc (fetch_pc),
    .predict   (predict),
    .update    (update)
  );

  // next pc selection
  fetch_pc_unit u_fetch (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .predict     (predict),
    .fetch_pc    (fetch_pc)
  );

endmodule

// ==== logic/branch_target_table.sv ====
`timescale 1ns/100ps

module branch_target_table
  import bp_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  addr_t    lookup_pc,
  output predict_t predict,
  input  update_t  update
);

  // entry storage
  logic [BTB_ENTRIES-1:0] entry_valid;
  addr_t                  entry_pc     [BTB_ENTRIES];
  addr_t                  entry_target [BTB_ENTRIES];
  ctr_t                   entry_ctr    [BTB_ENTRIES];

  // round-robin allocation pointer
  slot_idx_t alloc_ptr;

  logic [BTB_ENTRIES-1:0] lookup_match;
  slot_idx_t              lookup_idx;
  logic                   lookup_any;

  logic [BTB_ENTRIES-1:0] update_match;
  slot_idx_t              update_idx;
  logic                   update_any;

  function automatic logic ctr_predicts_taken(input ctr_t c);
    return (c == WEAK_T) || (c == STRONG_T);
  endfunction

  // one step toward the outcome, saturating at both ends
  function automatic ctr_t ctr_step(input ctr_t c, input logic taken);
    ctr_t n;
    case (c)
      STRONG_NT: n = taken ? WEAK_NT  : STRONG_NT;
      WEAK_NT:   n = taken ? WEAK_T   : STRONG_NT;
      WEAK_T:    n = taken ? STRONG_T : WEAK_NT;
      default:   n = taken ? STRONG_T : WEAK_T;
    endcase
    return n;
  endfunction

  // compare against every valid entry, for lookup and for update
  always_comb begin
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      lookup_match[i] = entry_valid[i] && (entry_pc[i] == lookup_pc);
      update_match[i] = entry_valid[i] && (entry_pc[i] == update.pc);
    end
  end

  match_encoder u_lookup_enc (
    .match_vec (lookup_match),
    .index     (lookup_idx),
    .any       (lookup_any)
  );

  match_encoder u_update_enc (
    .match_vec (update_match),
    .index     (update_idx),
    .any       (update_any)
  );

  // lookup answer, combinational on the fetch pc
  assign predict.taken  = lookup_any && ctr_predicts_taken(entry_ctr[lookup_idx]);
  assign predict.target = entry_target[lookup_idx];

  // valid bits and pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      entry_valid <= '0;
      alloc_ptr   <= '0;
    end else if (update.valid && !update_any) begin
      entry_valid[alloc_ptr] <= 1'b1;
      // wraps at 32 on its own
      alloc_ptr <= alloc_ptr + 1'b1;
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (update.valid) begin
      if (update_any) begin
        entry_ctr[update_idx] <= ctr_step(entry_ctr[update_idx], update.taken);
        // not-taken outcomes keep the old target
        if (update.taken) begin
          entry_target[update_idx] <= update.target;
        end
      end else begin
        entry_pc[alloc_ptr]     <= update.pc;
        entry_target[alloc_ptr] <= update.target;
        entry_ctr[alloc_ptr]    <= update.taken ? STRONG_T : STRONG_NT;
      end
    end
  end

endmodule

// ==== logic/fetch_pc_unit.sv ====
`timescale 1ns/100ps

module fetch_pc_unit
  import bp_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  logic     redirect,
  input  addr_t    redirect_pc,
  input  predict_t predict,
  output addr_t    fetch_pc
);

  addr_t fetch_pc_q;
  addr_t next_pc;

  // predicted target or fall through
  assign next_pc = predict.taken ? predict.target : fetch_pc_q + addr_t'(INSTR_BYTES);

  // redirect beats stall, stall beats normal advance
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_pc_q <= RESET_PC;
    end else if (redirect) begin
      fetch_pc_q <= redirect_pc;
    end else if (!stall) begin
      fetch_pc_q <= next_pc;
    end
  end

  assign fetch_pc = fetch_pc_q;

endmodule

// ==== logic/match_encoder.sv ====
`timescale 1ns/100ps

module match_encoder
  import bp_pkg::*;
(
  input  logic [BTB_ENTRIES-1:0] match_vec,
  output slot_idx_t              index,
  output logic                   any
);

  // lowest set bit wins
  // the table never holds two entries with the same pc, so at most one bit is set
  always_comb begin
    index = '0;
    for (int i = BTB_ENTRIES - 1; i >= 0; i--) begin
      if (match_vec[i]) begin
        index = slot_idx_t'(i);
      end
    end
  end

  assign any = |match_vec;

endmodule

// ==== logic/resolve_stage.sv ====
`timescale 1ns/100ps

module resolve_stage
  import bp_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  resolve_t resolve,
  output update_t  update,
  output logic     redirect,
  output addr_t    redirect_pc,
  output logic     mispredict
);

  resolve_t rec_q;
  addr_t    actual_next;

  // stage register for the incoming record
  always_ff @(posedge clk) begin
    if (reset) begin
      rec_q.valid <= 1'b0;
    end else begin
      rec_q <= resolve;
    end
  end

  // where execution really goes after this instruction
  assign actual_next = rec_q.taken ? rec_q.target : rec_q.pc + addr_t'(INSTR_BYTES);

  assign mispredict  = rec_q.valid && (actual_next != rec_q.pred_next);
  assign redirect    = mispredict;
  assign redirect_pc = actual_next;

  // jumps through registers and flushes never touch the table
  assign update.valid  = rec_q.valid && rec_q.branch;
  assign update.taken  = rec_q.taken;
  assign update.pc     = rec_q.pc;
  assign update.target = rec_q.target;

endmodule

// ==== src.f ====
logic/bp_pkg.sv
logic/match_encoder.sv
logic/branch_target_table.sv
logic/resolve_stage.sv
logic/fetch_pc_unit.sv
logic/branch_predictor.sv
tb/branch_predictor_sva.sv
tb/branch_predictor_tb.sv

// ==== tb/branch_predictor_sva.sv ====
`timescale 1ns/100ps

module branch_predictor_sva
  import bp_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     stall,
  input logic     mispredict,
  input logic     redirect,
  input addr_t    redirect_pc,
  input addr_t    fetch_pc,
  input predict_t predict
);

  // read by the testbench at the end of the run
  int fail_count = 0;

  hold_under_stall: assert property (@(posedge clk) disable iff (reset)
    (stall && !redirect) |=> (fetch_pc == $past(fetch_pc)))
    else begin
      $error("fetch_pc moved while stalled");
      fail_count = fail_count + 1;
    end

  // plain sequential step
  sequential_step: assert property (@(posedge clk) disable iff (reset)
    (!stall && !redirect && !predict.taken) |=> (fetch_pc == $past(fetch_pc) + 32'd4))
    else begin
      $error("fetch_pc did not advance by 4");
      fail_count = fail_count + 1;
    end

  quiet_in_reset: assert property (@(posedge clk)
    reset |=> !mispredict)
    else begin
      $error("mispredict high during reset");
      fail_count = fail_count + 1;
    end

  redirect_lands: assert property (@(posedge clk) disable iff (reset)
    mispredict |=> (fetch_pc == $past(redirect_pc)))
    else begin
      $error("fetch_pc missed the redirect target");
      fail_count = fail_count + 1;
    end

endmodule

// ==== tb/branch_predictor_tb.sv ====
`timescale 1ns/100ps

module branch_predictor_tb
  import bp_pkg::*;
();

  // the tests use well under 1000 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic     clk;
  logic     reset;
  logic     stall;
  resolve_t resolve;
  addr_t    fetch_pc;
  predict_t predict;
  logic     mispredict;

  int error_count = 0;
  int cycle_count = 0;

  // reference table
  logic  ref_valid  [BTB_ENTRIES];
  addr_t ref_pc     [BTB_ENTRIES];
  addr_t ref_target [BTB_ENTRIES];
  int    ref_ctr    [BTB_ENTRIES];
  int    ref_ptr;

  branch_predictor uut (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .resolve    (resolve),
    .fetch_pc   (fetch_pc),
    .predict    (predict),
    .mispredict (mispredict)
  );

  bind branch_predictor branch_predictor_sva sva_checks (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .mispredict  (mispredict),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_pc    (fetch_pc),
    .predict     (predict)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic clear_reference();
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      ref_valid[i]  = 1'b0;
      ref_pc[i]     = '0;
      ref_target[i] = '0;
      ref_ctr[i]    = 0;
    end
    ref_ptr = 0;
  endtask

  // counter 0..3, taken from 2 upward
  task automatic update_reference(input logic taken, input addr_t pc, input addr_t target);
    int hit;
    hit = -1;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      if (ref_valid[i] && ref_pc[i] == pc) begin
        hit = i;
      end
    end
    if (hit >= 0) begin
      if (taken && ref_ctr[hit] < 3) begin
        ref_ctr[hit]++;
      end else if (!taken && ref_ctr[hit] > 0) begin
        ref_ctr[hit]--;
      end
      if (taken) begin
        ref_target[hit] = target;
      end
    end else begin
      ref_valid[ref_ptr]  = 1'b1;
      ref_pc[ref_ptr]     = pc;
      ref_target[ref_ptr] = target;
      ref_ctr[ref_ptr]    = taken ? 3 : 0;
      ref_ptr             = (ref_ptr + 1) % BTB_ENTRIES;
    end
  endtask

  task automatic lookup_reference(input addr_t pc, output logic taken, output addr_t target);
    taken  = 1'b0;
    target = '0;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      if (ref_valid[i] && ref_pc[i] == pc && ref_ctr[i] >= 2) begin
        taken  = 1'b1;
        target = ref_target[i];
      end
    end
  endtask

  function automatic resolve_t build_record(input logic branch, input logic taken,
                                            input addr_t pc, input addr_t target,
                                            input addr_t pred_next);
    resolve_t rec;
    rec           = '0;
    rec.valid     = 1'b1;
    rec.branch    = branch;
    rec.taken     = taken;
    rec.pc        = pc;
    rec.target    = target;
    rec.pred_next = pred_next;
    return rec;
  endfunction

  // one resolve record, returns at the negedge after the table write
  task automatic send_resolve(input string name, input logic branch, input logic taken,
                              input addr_t pc, input addr_t target, input addr_t pred_next);
    addr_t actual;
    logic  exp_mis;
    actual  = taken ? target : pc + 32'd4;
    exp_mis = (actual != pred_next);
    @(posedge clk);
    resolve <= build_record(branch, taken, pc, target, pred_next);
    @(posedge clk);
    resolve <= '0;
    @(negedge clk);
    compare({name, " mispredict"}, 32'(exp_mis), 32'(mispredict));
    @(posedge clk);
    if (branch) begin
      update_reference(taken, pc, target);
    end
    @(negedge clk);
    if (exp_mis) begin
      compare({name, " redirect fetch_pc"}, actual, fetch_pc);
    end
  endtask

  // steer fetch to pc, then read the prediction there
  task automatic probe_pc(input string name, input addr_t pc);
    logic  exp_taken;
    addr_t exp_target;
    addr_t exp_next;
    send_resolve({name, " steer"}, 1'b0, 1'b1, pc, pc, pc + 32'd4);
    lookup_reference(pc, exp_taken, exp_target);
    compare({name, " predict.taken"}, 32'(exp_taken), 32'(predict.taken));
    if (exp_taken) begin
      compare({name, " predict.target"}, exp_target, predict.target);
    end
    exp_next = exp_taken ? exp_target : pc + 32'd4;
    @(posedge clk);
    @(negedge clk);
    compare({name, " next fetch_pc"}, exp_next, fetch_pc);
  endtask

  task automatic reset_and_sequential();
    addr_t held;
    @(negedge clk);
    compare("reset fetch_pc", RESET_PC, fetch_pc);
    for (int i = 1; i <= 4; i++) begin
      @(negedge clk);
      compare("sequential fetch_pc", RESET_PC + addr_t'(4 * i), fetch_pc);
      compare("empty table predict.taken", 32'd0, 32'(predict.taken));
    end
    @(posedge clk);
    stall <= 1'b1;
    // the edge that drives stall still advances once
    held = RESET_PC + 32'd20;
    @(negedge clk);
    compare("stall entry", held, fetch_pc);
    repeat (3) begin
      @(negedge clk);
      compare("stall hold", held, fetch_pc);
    end
    @(posedge clk);
    stall <= 1'b0;
    @(negedge clk);
    @(negedge clk);
    compare("resume after stall", held + 32'd4, fetch_pc);
  endtask

  task automatic install_and_predict();
    send_resolve("install", 1'b1, 1'b1, 32'h0000_2000, 32'h0000_3000, 32'h0000_2004);
    probe_pc("install probe", 32'h0000_2000);
    send_resolve("correct prediction", 1'b1, 1'b1, 32'h0000_2000, 32'h0000_3000,
                 32'h0000_3000);
  endtask

  task automatic counter_hysteresis();
    // not-taken records carry a bogus target that must not be stored
    send_resolve("first not-taken", 1'b1, 1'b0, 32'h0000_2000, 32'h0000_7700, 32'h0000_2004);
    probe_pc("weak taken probe", 32'h0000_2000);
    send_resolve("second not-taken", 1'b1, 1'b0, 32'h0000_2000, 32'h0000_7700, 32'h0000_2004);
    probe_pc("weak not-taken probe", 32'h0000_2000);
    send_resolve("install not-taken", 1'b1, 1'b0, 32'h0000_4000, 32'h0000_5000, 32'h0000_4004);
    probe_pc("strong not-taken probe", 32'h0000_4000);
    send_resolve("first taken", 1'b1, 1'b1, 32'h0000_4000, 32'h0000_5000, 32'h0000_4004);
    probe_pc("one taken probe", 32'h0000_4000);
    send_resolve("second taken", 1'b1, 1'b1, 32'h0000_4000, 32'h0000_5000, 32'h0000_4004);
    probe_pc("two taken probe", 32'h0000_4000);
  endtask

  task automatic target_replacement();
    send_resolve("install old target", 1'b1, 1'b1, 32'h0000_6000, 32'h0000_6100,
                 32'h0000_6004);
    send_resolve("new target", 1'b1, 1'b1, 32'h0000_6000, 32'h0000_6200, 32'h0000_6100);
    probe_pc("replaced target probe", 32'h0000_6000);
  endtask

  task automatic round_robin_eviction(output addr_t kept_pc);
    addr_t pcs  [33];
    addr_t tgts [33];
    addr_t cand;
    logic  dup;
    for (int i = 0; i < 33; i++) begin
      // distinct word-aligned pcs
      do begin
        cand = $urandom() & 32'hFFFF_FFFC;
        dup  = 1'b0;
        for (int j = 0; j < i; j++) begin
          if (pcs[j] == cand) begin
            dup = 1'b1;
          end
        end
      end while (dup);
      pcs[i]  = cand;
      tgts[i] = $urandom() & 32'hFFFF_FFFC;
    end
    for (int i = 0; i < 33; i++) begin
      send_resolve($sformatf("fill %0d", i), 1'b1, 1'b1, pcs[i], tgts[i], pcs[i] + 32'd4);
    end
    for (int i = 0; i < 33; i++) begin
      probe_pc($sformatf("eviction probe %0d", i), pcs[i]);
    end
    kept_pc = pcs[5];
  endtask

  task automatic plain_redirect_and_pairs(input addr_t kept_pc);
    send_resolve("plain redirect", 1'b0, 1'b1, kept_pc, 32'h0000_9000, kept_pc + 32'd4);
    probe_pc("table untouched", kept_pc);
    // two records on consecutive cycles, both predicted right
    @(posedge clk);
    resolve <= build_record(1'b1, 1'b1, 32'h0000_8000, 32'h0000_8800, 32'h0000_8800);
    @(posedge clk);
    resolve <= build_record(1'b1, 1'b1, 32'h0000_8100, 32'h0000_8900, 32'h0000_8900);
    @(negedge clk);
    compare("pair first mispredict", 32'd0, 32'(mispredict));
    @(posedge clk);
    resolve <= '0;
    @(negedge clk);
    compare("pair second mispredict", 32'd0, 32'(mispredict));
    @(posedge clk);
    update_reference(1'b1, 32'h0000_8000, 32'h0000_8800);
    update_reference(1'b1, 32'h0000_8100, 32'h0000_8900);
    @(negedge clk);
    probe_pc("pair first probe", 32'h0000_8000);
    probe_pc("pair second probe", 32'h0000_8100);
  endtask

  initial begin
    addr_t kept_pc;
    int    total;
    reset   = 1'b1;
    stall   = 1'b0;
    resolve = '0;
    void'($urandom(23486));
    clear_reference();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    reset_and_sequential();
    install_and_predict();
    counter_hysteresis();
    target_replacement();
    round_robin_eviction(kept_pc);
    plain_redirect_and_pairs(kept_pc);
    @(negedge clk);
    total = error_count + uut.sva_checks.fail_count;
    $display("errors: %0d check, %0d assertion", error_count, uut.sva_checks.fail_count);
    if (total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
